// ==== motor_golden.txt ====
// one 64-bit word per line: op(1) addr(1) data(8) extra(6) hex digits
// op 1 APB write, op 2 APB read with data expected, extra[0] expected pslverr
// op 3 pins {aHigh aLowN bHigh bLowN cHigh cLowN} in data[5:0], hold cycles in data[31:16]
// op 3 extra[15:0] timeout cycles, extra[16] dead-time gap check, op 0 ends the list
2_8_00000000_000000
3_0_00000015_000000
1_4_000001F4_000000
2_4_000003E8_000000
1_4_000003FC_000000
2_4_000003FC_000000
2_C_00000000_000001
1_4_000003E8_000000
// forward run, steps 0 to 5 and the wrap to 0
1_0_00000001_000000
3_0_03E40031_000014
3_0_03E40034_010014
3_0_03E4001C_010014
3_0_03E4000D_010014
3_0_03E40007_010014
3_0_03E40013_010014
3_0_00000031_010014
// reverse, step 0 is followed by step 5
1_0_00000003_000000
3_0_03E40013_000500
3_0_03E40007_010014
3_0_03E4000D_010014
3_0_03E4001C_010014
3_0_03E40034_010014
3_0_03E40031_010014
3_0_00000013_010014
// forceStop, pins off within dead time plus 3
1_0_00000004_000000
3_0_00000015_000007
2_8_00000005_000000
0_0_00000000_000000

// ==== src.f ====
+incdir+.
motorPkg.sv
motorApbRegs.sv
commutationSequencer.sv
phaseLegDriver.sv
gateOutputStage.sv
motorDriveTop.sv
motorDrive_properties.sv
motorDriveTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the motor drive testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module motorDriveTb -f src.f \
    && ./obj_dir/VmotorDriveTb +verilator+error+limit+100 | tee sim.log

grep -qx "All checks passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== motorDriveTb.sv ====
`timescale 1ns/1ps
`include "motor_macros.svh"

module motorDriveTb;

    localparam int goldenDepth = 64;
    localparam int apbTimeout  = 16;
    // high pins 0, active-low low pins 1
    localparam logic [5:0] pinsOff = 6'b010101;

    logic             clk;
    logic             nRst;
    motorPkg::apbReqT apbReq;
    motorPkg::apbRspT apbRsp;
    logic             aHigh;
    logic             aLowN;
    logic             bHigh;
    logic             bLowN;
    logic             cHigh;
    logic             cLowN;
    logic [63:0]      golden [goldenDepth];
    int               errCount;
    int               checkCount;

    motorDriveTop motorDriveTop_inst (
        .clk    (clk),
        .nRst   (nRst),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .aHigh  (aHigh),
        .aLowN  (aLowN),
        .bHigh  (bHigh),
        .bLowN  (bLowN),
        .cHigh  (cHigh),
        .cLowN  (cLowN)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [5:0] pinState();
        return {aHigh, aLowN, bHigh, bLowN, cHigh, cLowN};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            $display("FAIL %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // APB transfer started 2 ns after a rising edge
    // ------------------------------------------------------------------
    task automatic apbAccess(input logic write, input logic [3:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        int waitCnt;
        waitCnt        = 0;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge clk);
        #2;
        apbReq.penable = 1'b1;
        // sample mid access phase
        @(negedge clk);
        while (!apbRsp.pready && waitCnt < apbTimeout) begin
            @(negedge clk);
            waitCnt++;
        end
        checkCount++;
        assert (apbRsp.pready) else begin
            errCount++;
            $display("APB transfer to address 0x%0h never completed at %0t", addr, $time);
        end
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(posedge clk);
        #2;
        apbReq = '0;
    endtask

    task automatic waitPattern(input logic [5:0] pat, input int timeout, output int waited);
        waited = 0;
        while (pinState() !== pat && waited < timeout) begin
            @(posedge clk);
            #2;
            waited++;
        end
        checkCount++;
        assert (pinState() === pat) else begin
            errCount++;
            $display("FAIL %0t pins got %06b expected %06b after %0d cycles",
                     $time, pinState(), pat, waited);
        end
    endtask

    task automatic measureHold(input logic [5:0] pat, input int limit, output int held);
        held = 0;
        while (pinState() === pat && held <= limit) begin
            @(posedge clk);
            #2;
            held++;
        end
    endtask

    // data[5:0] pattern, data[31:16] hold, extra[15:0] timeout, extra[16] gap check
    task automatic checkPattern(input logic [31:0] data, input logic [23:0] extra);
        int holdCycles;
        int timeout;
        int waited;
        int held;
        holdCycles = int'(data[31:16]);
        timeout    = int'(extra[15:0]);
        waitPattern(data[5:0], timeout, waited);
        if (extra[16]) begin
            checkCount++;
            assert (waited >= `MOTOR_DEAD_TIME) else begin
                errCount++;
                $display("FAIL %0t dead time got %0d expected at least %0d",
                         $time, waited, `MOTOR_DEAD_TIME);
            end
        end
        if (holdCycles != 0) begin
            measureHold(data[5:0], holdCycles + 16, held);
            checkValue("hold cycles", 32'(held), 32'(holdCycles));
        end
    endtask

    // ------------------------------------------------------------------
    // pin monitor
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        assert (!(aHigh && !aLowN) && !(bHigh && !bLowN) && !(cHigh && !cLowN)) else begin
            errCount++;
            $display("shoot-through at %0t, a leg had both switches on, pins %06b",
                     $time, pinState());
        end
        if (!nRst) begin
            assert (pinState() === pinsOff) else begin
                errCount++;
                $display("FAIL %0t pins got %06b expected %06b", $time, pinState(), pinsOff);
            end
        end
    end

    initial begin : mainSequence
        logic [63:0] entry;
        logic [3:0]  op;
        logic [31:0] rdata;
        logic        err;
        int          idx;
        logic        done;
        errCount   = 0;
        checkCount = 0;
        apbReq     = '0;
        nRst       = 1'b1;
        for (int i = 0; i < goldenDepth; i++) begin
            golden[i] = '0;
        end
        $readmemh("motor_golden.txt", golden);
        #1;
        nRst = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        nRst = 1'b1;
        @(posedge clk);
        #2;
        idx  = 0;
        done = 1'b0;
        while (!done && idx < goldenDepth) begin
            entry = golden[idx];
            op    = entry[63:60];
            case (op)
                4'h0: done = 1'b1;
                4'h1: begin
                    apbAccess(1'b1, entry[59:56], entry[55:24], rdata, err);
                    checkValue("pslverr", {31'd0, err}, {31'd0, entry[0]});
                end
                4'h2: begin
                    apbAccess(1'b0, entry[59:56], 32'd0, rdata, err);
                    checkValue("prdata", rdata, entry[55:24]);
                    checkValue("pslverr", {31'd0, err}, {31'd0, entry[0]});
                end
                4'h3: checkPattern(entry[55:24], entry[23:0]);
                default: begin
                    checkCount++;
                    assert (op <= 4'h3) else begin
                        errCount++;
                        $display("golden line %0d has an unknown opcode %0h", idx, op);
                    end
                end
            endcase
            idx++;
        end
        assert (checkCount > 0) else begin
            errCount++;
            $display("no checks ran, the golden file is empty or missing");
        end
        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== motorDrive_properties.sv ====
`timescale 1ns/1ps
`include "motor_macros.svh"

module motorDriveProperties (
    input logic clk,
    input logic nRst,
    input logic aHigh,
    input logic aLowN,
    input logic bHigh,
    input logic bLowN,
    input logic cHigh,
    input logic cLowN
);

    logic [2:0] highV;
    logic [2:0] lowV;
    logic [2:0] legOff;

    assign highV  = {cHigh, bHigh, aHigh};
    assign lowV   = {~cLowN, ~bLowN, ~aLowN};
    assign legOff = ~highV & ~lowV;

    // ------------------------------------------------------------------
    // per-leg shoot-through and dead time
    // ------------------------------------------------------------------
    for (genvar i = 0; i < 3; i++) begin : genLegProps
        logic [`MOTOR_DEAD_TIME-1:0] offHist;

        // last few cycles of the leg being fully off
        always_ff @(posedge clk or negedge nRst) begin
            if (!nRst) begin
                offHist <= '1;
            end else begin
                offHist <= {offHist[`MOTOR_DEAD_TIME-2:0], legOff[i]};
            end
        end

        noShootThrough: assert property (@(posedge clk) disable iff (!nRst)
            !(highV[i] && lowV[i]))
            else $error("leg %0d has high and low switch on together", i);

        highDeadTime: assert property (@(posedge clk) disable iff (!nRst)
            $rose(highV[i]) |-> &offHist)
            else $error("leg %0d high switch on without full dead time", i);

        lowDeadTime: assert property (@(posedge clk) disable iff (!nRst)
            $rose(lowV[i]) |-> &offHist)
            else $error("leg %0d low switch on without full dead time", i);
    end

    offInReset: assert property (@(posedge clk)
        !nRst |-> (highV == 3'b000 && lowV == 3'b000))
        else $error("gate pins not off during reset");

endmodule

bind motorDriveTop motorDriveProperties motorDriveProperties_inst (
    .clk   (clk),
    .nRst  (nRst),
    .aHigh (aHigh),
    .aLowN (aLowN),
    .bHigh (bHigh),
    .bLowN (bLowN),
    .cHigh (cHigh),
    .cLowN (cLowN)
);

// ==== motorDriveTop.sv ====
`timescale 1ns/1ps

module motorDriveTop (
    input  logic             clk,
    input  logic             nRst,
    input  motorPkg::apbReqT apbReq,
    output motorPkg::apbRspT apbRsp,
    output logic             aHigh,
    output logic             aLowN,
    output logic             bHigh,
    output logic             bLowN,
    output logic             cHigh,
    output logic             cLowN
);

    motorPkg::driveCfgT      cfg;
    motorPkg::stepT          step;
    logic                    running;
    motorPkg::phaseCmdsT     cmds;
    motorPkg::phaseCmdT      legCmd [3];
    motorPkg::legGateT [2:0] legGates;

    motorApbRegs motorApbRegs_inst (
        .clk     (clk),
        .nRst    (nRst),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp),
        .step    (step),
        .running (running),
        .cfg     (cfg)
    );

    commutationSequencer commutationSequencer_inst (
        .clk     (clk),
        .nRst    (nRst),
        .cfg     (cfg),
        .cmds    (cmds),
        .step    (step),
        .running (running)
    );

    // ------------------------------------------------------------------
    // one leg driver per phase
    // ------------------------------------------------------------------
    assign legCmd[0] = cmds.a;
    assign legCmd[1] = cmds.b;
    assign legCmd[2] = cmds.c;

    for (genvar i = 0; i < 3; i++) begin : genLeg
        phaseLegDriver phaseLegDriver_inst (
            .clk  (clk),
            .nRst (nRst),
            .cmd  (legCmd[i]),
            .gate (legGates[i])
        );
    end

    gateOutputStage gateOutputStage_inst (
        .clk   (clk),
        .nRst  (nRst),
        .legs  (legGates),
        .aHigh (aHigh),
        .aLowN (aLowN),
        .bHigh (bHigh),
        .bLowN (bLowN),
        .cHigh (cHigh),
        .cLowN (cLowN)
    );

endmodule

// ==== gateOutputStage.sv ====
`timescale 1ns/1ps

module gateOutputStage (
    input  logic                    clk,
    input  logic                    nRst,
    input  motorPkg::legGateT [2:0] legs,
    output logic                    aHigh,
    output logic                    aLowN,
    output logic                    bHigh,
    output logic                    bLowN,
    output logic                    cHigh,
    output logic                    cLowN
);

    logic [2:0] highQ;
    logic [2:0] lowNQ;

    // index 0 is phase a, 2 is phase c
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            highQ <= '0;
            lowNQ <= '1;
        end else begin
            for (int i = 0; i < 3; i++) begin
                // shoot-through guard turns a leg with both enables set fully off
                highQ[i] <= legs[i].highOn & ~legs[i].lowOn;
                lowNQ[i] <= ~(legs[i].lowOn & ~legs[i].highOn);
            end
        end
    end

    assign aHigh = highQ[0];
    assign aLowN = lowNQ[0];
    assign bHigh = highQ[1];
    assign bLowN = lowNQ[1];
    assign cHigh = highQ[2];
    assign cLowN = lowNQ[2];

endmodule

// ==== phaseLegDriver.sv ====
`timescale 1ns/1ps
`include "motor_macros.svh"

module phaseLegDriver (
    input  logic               clk,
    input  logic               nRst,
    input  motorPkg::phaseCmdT cmd,
    output motorPkg::legGateT  gate
);

    motorPkg::phaseCmdT lastCmd;
    motorPkg::deadCntT  deadCnt;
    motorPkg::legGateT  gateQ;
    logic               cmdChange;

    assign cmdChange = (cmd != lastCmd);

    // ------------------------------------------------------------------
    // dead-time insertion
    // ------------------------------------------------------------------
    // a change drops both switches on the next edge, the new switch comes
    // on only after MOTOR_DEAD_TIME cycles with the leg fully off
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            lastCmd      <= motorPkg::FLOAT;
            deadCnt      <= '0;
            gateQ.highOn <= 1'b0;
            gateQ.lowOn  <= 1'b0;
        end else if (cmdChange) begin
            lastCmd      <= cmd;
            deadCnt      <= motorPkg::deadCntT'(`MOTOR_DEAD_TIME - 1);
            gateQ.highOn <= 1'b0;
            gateQ.lowOn  <= 1'b0;
        end else if (deadCnt != '0) begin
            deadCnt      <= motorPkg::deadCntT'(deadCnt - 1'b1);
            gateQ.highOn <= 1'b0;
            gateQ.lowOn  <= 1'b0;
        end else begin
            gateQ.highOn <= (lastCmd == motorPkg::DRIVE_HIGH);
            gateQ.lowOn  <= (lastCmd == motorPkg::DRIVE_LOW);
        end
    end

    assign gate = gateQ;

endmodule

// ==== commutationSequencer.sv ====
`timescale 1ns/1ps
`include "motor_macros.svh"

module commutationSequencer (
    input  logic                clk,
    input  logic                nRst,
    input  motorPkg::driveCfgT  cfg,
    output motorPkg::phaseCmdsT cmds,
    output motorPkg::stepT      step,
    output logic                running
);

    motorPkg::seqStateT state;
    motorPkg::stepT     stepQ;
    motorPkg::periodT   periodQ;
    motorPkg::periodT   cnt;
    logic               stepWrap;

    // last cycle of the current step
    assign stepWrap = (cnt == motorPkg::periodT'(periodQ - 1'b1));

    // ------------------------------------------------------------------
    // state machine and step timer
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state   <= motorPkg::IDLE;
            stepQ   <= '0;
            cnt     <= '0;
            periodQ <= motorPkg::periodT'(`MOTOR_MIN_PERIOD);
        end else begin
            case (state)
                motorPkg::IDLE: begin
                    if (cfg.run) begin
                        state   <= motorPkg::RUN;
                        stepQ   <= '0;
                        cnt     <= '0;
                        periodQ <= cfg.period;
                    end
                end
                motorPkg::RUN: begin
                    if (!cfg.run) begin
                        state <= motorPkg::IDLE;
                    end else if (stepWrap) begin
                        cnt     <= '0;
                        // new period only takes hold at a step boundary
                        periodQ <= cfg.period;
                        if (cfg.reverse) begin
                            stepQ <= (stepQ == '0) ? motorPkg::stepT'(5)
                                                   : motorPkg::stepT'(stepQ - 1'b1);
                        end else begin
                            stepQ <= (stepQ == motorPkg::stepT'(5)) ? '0
                                                   : motorPkg::stepT'(stepQ + 1'b1);
                        end
                    end else begin
                        cnt <= motorPkg::periodT'(cnt + 1'b1);
                    end
                end
                default: state <= motorPkg::IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // six-step table with phases in a, b, c order
    // ------------------------------------------------------------------
    always_comb begin
        cmds.a = motorPkg::FLOAT;
        cmds.b = motorPkg::FLOAT;
        cmds.c = motorPkg::FLOAT;
        if (state == motorPkg::RUN) begin
            case (stepQ)
                3'd0: begin
                    cmds.a = motorPkg::DRIVE_HIGH;
                    cmds.b = motorPkg::DRIVE_LOW;
                end
                3'd1: begin
                    cmds.a = motorPkg::DRIVE_HIGH;
                    cmds.c = motorPkg::DRIVE_LOW;
                end
                3'd2: begin
                    cmds.b = motorPkg::DRIVE_HIGH;
                    cmds.c = motorPkg::DRIVE_LOW;
                end
                3'd3: begin
                    cmds.a = motorPkg::DRIVE_LOW;
                    cmds.b = motorPkg::DRIVE_HIGH;
                end
                3'd4: begin
                    cmds.a = motorPkg::DRIVE_LOW;
                    cmds.c = motorPkg::DRIVE_HIGH;
                end
                3'd5: begin
                    cmds.b = motorPkg::DRIVE_LOW;
                    cmds.c = motorPkg::DRIVE_HIGH;
                end
                default: ;
            endcase
        end
    end

    assign step    = stepQ;
    assign running = (state == motorPkg::RUN);

endmodule

// ==== motorApbRegs.sv ====
`timescale 1ns/1ps
`include "motor_macros.svh"

module motorApbRegs (
    input  logic              clk,
    input  logic              nRst,
    input  motorPkg::apbReqT  apbReq,
    output motorPkg::apbRspT  apbRsp,
    input  motorPkg::stepT    step,
    input  logic              running,
    output motorPkg::driveCfgT cfg
);

    motorPkg::driveCfgT cfgQ;
    motorPkg::periodT   wrPeriod;
    motorPkg::apbDataT  rdData;
    logic               access;
    logic               wrEn;
    logic               mapped;

    // zero wait state, so the access phase is the whole transfer
    assign access = apbReq.psel & apbReq.penable;
    assign wrEn   = access & apbReq.pwrite;

    assign wrPeriod = apbReq.pwdata[`MOTOR_PERIOD_W-1:0];

    always_comb begin
        case (apbReq.paddr)
            `MOTOR_REG_CTRL,
            `MOTOR_REG_PERIOD,
            `MOTOR_REG_STATUS: mapped = 1'b1;
            default:           mapped = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // control and period registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            cfgQ.run     <= 1'b0;
            cfgQ.reverse <= 1'b0;
            cfgQ.period  <= motorPkg::periodT'(`MOTOR_MIN_PERIOD);
        end else if (wrEn) begin
            if (apbReq.paddr == `MOTOR_REG_CTRL) begin
                // forceStop in bit2 wins over a run request in the same write
                cfgQ.run     <= apbReq.pwdata[0] & ~apbReq.pwdata[2];
                cfgQ.reverse <= apbReq.pwdata[1];
            end else if (apbReq.paddr == `MOTOR_REG_PERIOD) begin
                if (wrPeriod < motorPkg::periodT'(`MOTOR_MIN_PERIOD)) begin
                    cfgQ.period <= motorPkg::periodT'(`MOTOR_MIN_PERIOD);
                end else begin
                    cfgQ.period <= wrPeriod;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // combinational read mux in the access phase
    // ------------------------------------------------------------------
    always_comb begin
        rdData = '0;
        if (access && !apbReq.pwrite) begin
            case (apbReq.paddr)
                `MOTOR_REG_CTRL: begin
                    rdData[0] = cfgQ.run;
                    rdData[1] = cfgQ.reverse;
                end
                `MOTOR_REG_PERIOD: rdData[`MOTOR_PERIOD_W-1:0] = cfgQ.period;
                `MOTOR_REG_STATUS: begin
                    // step in the low bits, running just above it
                    rdData[`MOTOR_STEP_W-1:0] = step;
                    rdData[`MOTOR_STEP_W]     = running;
                end
                default: rdData = '0;
            endcase
        end
    end

    assign apbRsp.prdata  = rdData;
    assign apbRsp.pready  = 1'b1;
    assign apbRsp.pslverr = access & ~mapped;

    assign cfg = cfgQ;

endmodule

// ==== motorPkg.sv ====
`include "motor_macros.svh"

package motorPkg;

    // widths with a meaning of their own
    typedef logic [`MOTOR_PERIOD_W-1:0] periodT;
    typedef logic [`MOTOR_STEP_W-1:0]   stepT;
    typedef logic [`MOTOR_DEAD_W-1:0]   deadCntT;
    typedef logic [`MOTOR_ADDR_W-1:0]   apbAddrT;
    typedef logic [`MOTOR_DATA_W-1:0]   apbDataT;

    typedef enum logic [1:0] {
        FLOAT,
        DRIVE_HIGH,
        DRIVE_LOW
    } phaseCmdT;

    typedef enum logic {
        IDLE,
        RUN
    } seqStateT;

    typedef struct packed {
        logic   run;
        logic   reverse;
        periodT period;
    } driveCfgT;

    typedef struct packed {
        phaseCmdT a;
        phaseCmdT b;
        phaseCmdT c;
    } phaseCmdsT;

    // per-leg switch enables, both active high
    typedef struct packed {
        logic highOn;
        logic lowOn;
    } legGateT;

    typedef struct packed {
        logic    psel;
        logic    penable;
        logic    pwrite;
        apbAddrT paddr;
        apbDataT pwdata;
    } apbReqT;

    typedef struct packed {
        apbDataT prdata;
        logic    pready;
        logic    pslverr;
    } apbRspT;

endpackage

// ==== motor_macros.svh ====
`ifndef MOTOR_MACROS_SVH
`define MOTOR_MACROS_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
`define MOTOR_PERIOD_W   10
`define MOTOR_STEP_W     3
`define MOTOR_DEAD_W     3
`define MOTOR_ADDR_W     4
`define MOTOR_DATA_W     32

// ----------------------------------------------------------------------
// register map and drive constants
// ----------------------------------------------------------------------
`define MOTOR_REG_CTRL   4'h0
`define MOTOR_REG_PERIOD 4'h4
`define MOTOR_REG_STATUS 4'h8

`define MOTOR_MIN_PERIOD 1000
`define MOTOR_DEAD_TIME  4

`endif
